// ==== rtl/acc_settings.svh ====
`ifndef ACC_SETTINGS_SVH
`define ACC_SETTINGS_SVH

////////////////////////////////////////
// Array geometry
////////////////////////////////////////

// Width of one ifmap or filter operand
`define ACC_DATA_WIDTH 16

// PE rows in the array
`define ACC_NUM_ROW 4

// PEs in each row
`define ACC_NUM_COL 4

// Count bits plus one, so the value 4 can mean "all"
`define ACC_TAG_WIDTH 3

`endif

// ==== rtl/bus_if.sv ====
`timescale 1ns/1ps
`include "acc_settings.svh"

////////////////////////////////////////
// Column bus, one shared by all rows
////////////////////////////////////////

interface y_bus_if;
    import noc_pkg::*;
    import pe_pkg::*;

    // Per-row accept strobe
    logic [`ACC_NUM_ROW-1:0] row_sel;
    // Column destination for the word in flight
    col_tag_t col_tag;
    operand_t ifmap;
    operand_t fltr;
    // Window restart, kept in order with the data
    logic     flush_kernel;
    ksize_t   kernel_size;

    modport ctrl (output row_sel, col_tag, ifmap, fltr, flush_kernel, kernel_size);
    modport row  (input  row_sel, col_tag, ifmap, fltr, flush_kernel, kernel_size);
endinterface

////////////////////////////////////////
// Row bus, one per row
////////////////////////////////////////

interface x_bus_if;
    import pe_pkg::*;

    // Per-PE accept strobe
    logic [`ACC_NUM_COL-1:0] pe_sel;
    operand_t ifmap;
    operand_t fltr;
    logic     flush_kernel;
    ksize_t   kernel_size;

    modport bus (output pe_sel, ifmap, fltr, flush_kernel, kernel_size);
    modport pe  (input  pe_sel, ifmap, fltr, flush_kernel, kernel_size);
endinterface

// ==== rtl/col_bus_ctrl.sv ====
`timescale 1ns/1ps
`include "acc_settings.svh"

module col_bus_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush_tag,
    input  logic               word_valid,
    input  noc_pkg::bus_word_u bus_word,
    input  logic               flush_kernel,
    input  pe_pkg::ksize_t     kernel_size,
    y_bus_if.ctrl              ybus
);
    import noc_pkg::*;
    import pe_pkg::*;

    // Stored destination
    row_tag_t row_tag_q;
    col_tag_t col_tag_q;
    // Rows hit by the stored tag
    logic [`ACC_NUM_ROW-1:0] row_match;

    ////////////////////////////////////////
    // Tag capture
    ////////////////////////////////////////

    // Reset destination is every PE
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_tag_q <= ROW_ALL;
            col_tag_q <= COL_ALL;
        end else if (flush_tag) begin
            row_tag_q <= bus_word.cfg.row_tag;
            col_tag_q <= bus_word.cfg.col_tag;
        end
    end

    // Row decode, broadcast code hits every row
    always_comb begin
        for (int r = 0; r < `ACC_NUM_ROW; r++) begin
            row_match[r] = (row_tag_q == row_tag_t'(r)) || (row_tag_q == ROW_ALL);
        end
    end

    ////////////////////////////////////////
    // Y bus stage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ybus.row_sel      <= '0;
            ybus.col_tag      <= COL_ALL;
            ybus.flush_kernel <= 1'b0;
        end else begin
            // Selects only for a data word
            ybus.row_sel      <= word_valid ? row_match : '0;
            ybus.col_tag      <= col_tag_q;
            ybus.flush_kernel <= flush_kernel;
        end
    end

    // Operands and size ride along unqualified
    always_ff @(posedge clk) begin
        ybus.ifmap       <= operand_t'(bus_word.data.ifmap);
        ybus.fltr        <= operand_t'(bus_word.data.fltr);
        ybus.kernel_size <= kernel_size;
    end

    // One word is either tag or data, never both
    a_tag_data_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(flush_tag && word_valid))
        else $error("flush_tag and word_valid high together");

endmodule

// ==== rtl/conv_pe.sv ====
`timescale 1ns/1ps
`include "acc_settings.svh"

module conv_pe #(
    parameter int COL_IDX = 0
) (
    input  logic          clk,
    input  logic          rstn,
    x_bus_if.pe           xbus,
    output logic          psum_valid,
    output pe_pkg::psum_t psum_data
);
    import pe_pkg::*;

    // Word accepted this cycle
    logic     sel;
    // Last word of the window
    logic     last;
    product_t product;
    psum_t    acc;
    psum_t    acc_next;
    // Words taken in the current window
    ksize_t   cnt;
    // Window length latched on flush
    ksize_t   win_len;

    assign sel = xbus.pe_sel[COL_IDX];

    ////////////////////////////////////////
    // Multiply and add
    ////////////////////////////////////////

    // Signed 16x16 into 32 bits
    assign product  = xbus.ifmap * xbus.fltr;
    assign acc_next = acc + psum_t'(product);
    // cnt stays below win_len so the increment cannot wrap
    assign last     = sel && (ksize_t'(cnt + 8'd1) == win_len);

    ////////////////////////////////////////
    // Window control
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc        <= '0;
            cnt        <= '0;
            win_len    <= 8'd1;
            psum_valid <= 1'b0;
            psum_data  <= '0;
        end else begin
            psum_valid <= 1'b0;
            if (xbus.flush_kernel) begin
                // Drop the partial window, take the new length
                // a word in the same cycle is lost
                acc     <= '0;
                cnt     <= '0;
                win_len <= xbus.kernel_size;
            end else if (sel) begin
                if (last) begin
                    // Emit and start the next window
                    psum_data  <= acc_next;
                    psum_valid <= 1'b1;
                    acc        <= '0;
                    cnt        <= '0;
                end else begin
                    acc <= acc_next;
                    cnt <= ksize_t'(cnt + 8'd1);
                end
            end
        end
    end

    // A zero window would never emit
    a_win_nonzero: assert property (@(posedge clk) disable iff (!rstn)
        win_len != '0)
        else $error("PE col %0d latched kernel_size 0", COL_IDX);

    a_cnt_in_window: assert property (@(posedge clk) disable iff (!rstn)
        cnt < win_len)
        else $error("PE col %0d count %0d past window %0d", COL_IDX, cnt, win_len);

endmodule

// ==== rtl/noc_pkg.sv ====
`include "acc_settings.svh"

package noc_pkg;

    // One bus word carries two operands
    localparam int BUS_WIDTH = 2 * `ACC_DATA_WIDTH;

    // Destination tags, one extra bit for the broadcast code
    typedef logic [`ACC_TAG_WIDTH-1:0] row_tag_t;
    typedef logic [`ACC_TAG_WIDTH-1:0] col_tag_t;

    // Broadcast codes, equal to the row and column counts
    localparam row_tag_t ROW_ALL = row_tag_t'(`ACC_NUM_ROW);
    localparam col_tag_t COL_ALL = col_tag_t'(`ACC_NUM_COL);

    // Data view, ifmap in the upper half
    typedef struct packed {
        logic [`ACC_DATA_WIDTH-1:0] ifmap;
        logic [`ACC_DATA_WIDTH-1:0] fltr;
    } bus_data_t;

    // Tag view, tags packed at the bottom of the word
    typedef struct packed {
        logic [BUS_WIDTH-2*`ACC_TAG_WIDTH-1:0] reserved;
        row_tag_t                               row_tag;
        col_tag_t                               col_tag;
    } bus_cfg_t;

    // Same 32 bits, read as cfg on flush_tag and as data on word_valid
    typedef union packed {
        bus_data_t data;
        bus_cfg_t  cfg;
    } bus_word_u;

endpackage

// ==== rtl/pe_array_top.sv ====
`timescale 1ns/1ps
`include "acc_settings.svh"

module pe_array_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush_tag,
    input  logic               word_valid,
    input  noc_pkg::bus_word_u bus_word,
    input  logic               flush_kernel,
    input  pe_pkg::ksize_t     kernel_size,
    // PE index is row * ACC_NUM_COL + col
    output logic [`ACC_NUM_ROW*`ACC_NUM_COL-1:0] psum_valid,
    output logic [`ACC_NUM_ROW*`ACC_NUM_COL*$bits(pe_pkg::psum_t)-1:0] psum_data
);

    localparam int PSUM_W = $bits(pe_pkg::psum_t);

    // Shared bus from the column stage to every row
    y_bus_if ybus ();

    ////////////////////////////////////////
    // Column stage
    ////////////////////////////////////////

    col_bus_ctrl u_col_bus_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .flush_tag    (flush_tag),
        .word_valid   (word_valid),
        .bus_word     (bus_word),
        .flush_kernel (flush_kernel),
        .kernel_size  (kernel_size),
        .ybus         (ybus)
    );

    ////////////////////////////////////////
    // Rows and PEs
    ////////////////////////////////////////

    for (genvar r = 0; r < `ACC_NUM_ROW; r++) begin : g_row
        // Private bus for this row's PEs
        x_bus_if xbus ();

        row_bus_ctrl #(.ROW_IDX(r)) u_row_bus_ctrl (
            .clk  (clk),
            .rstn (rstn),
            .ybus (ybus),
            .xbus (xbus)
        );

        for (genvar c = 0; c < `ACC_NUM_COL; c++) begin : g_col
            localparam int PE_IDX = r * `ACC_NUM_COL + c;

            conv_pe #(.COL_IDX(c)) u_pe (
                .clk        (clk),
                .rstn       (rstn),
                .xbus       (xbus),
                .psum_valid (psum_valid[PE_IDX]),
                .psum_data  (psum_data[PE_IDX*PSUM_W +: PSUM_W])
            );
        end
    end

endmodule

// ==== rtl/pe_pkg.sv ====
`include "acc_settings.svh"

package pe_pkg;

    // Signed operand as it arrives from the bus
    typedef logic signed [`ACC_DATA_WIDTH-1:0] operand_t;

    // Full precision product of two operands
    typedef logic signed [2*`ACC_DATA_WIDTH-1:0] product_t;

    // Partial sum, same width as one product
    // no guard bits, wraps on long windows
    typedef logic signed [2*`ACC_DATA_WIDTH-1:0] psum_t;

    // Kernel window length in words
    typedef logic [7:0] ksize_t;

endpackage

// ==== rtl/row_bus_ctrl.sv ====
`timescale 1ns/1ps
`include "acc_settings.svh"

module row_bus_ctrl #(
    parameter int ROW_IDX = 0
) (
    input  logic  clk,
    input  logic  rstn,
    y_bus_if.row  ybus,
    x_bus_if.bus  xbus
);
    import noc_pkg::*;

    // This row's strobe from the column stage
    logic                    row_hit;
    // PEs hit by the carried column tag
    logic [`ACC_NUM_COL-1:0] col_match;

    assign row_hit = ybus.row_sel[ROW_IDX];

    ////////////////////////////////////////
    // Column decode
    ////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < `ACC_NUM_COL; c++) begin
            col_match[c] = (ybus.col_tag == col_tag_t'(c)) || (ybus.col_tag == COL_ALL);
        end
    end

    ////////////////////////////////////////
    // X bus stage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            xbus.pe_sel       <= '0;
            xbus.flush_kernel <= 1'b0;
        end else begin
            // Nothing leaves unless this row was picked
            xbus.pe_sel       <= row_hit ? col_match : '0;
            // Flush goes to every row
            xbus.flush_kernel <= ybus.flush_kernel;
        end
    end

    // Operands forwarded as is
    // the PE select decides who uses them
    always_ff @(posedge clk) begin
        xbus.ifmap       <= ybus.ifmap;
        xbus.fltr        <= ybus.fltr;
        xbus.kernel_size <= ybus.kernel_size;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PE array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_pe_array -Mdir obj_dir -o tb_pe_array
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_pe_array > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0

// ==== sources.f ====
+incdir+rtl
rtl/noc_pkg.sv
rtl/pe_pkg.sv
rtl/bus_if.sv
rtl/col_bus_ctrl.sv
rtl/row_bus_ctrl.sv
rtl/conv_pe.sv
rtl/pe_array_top.sv
verif/tb_pe_array.sv

// ==== verif/tb_pe_array.sv ====
`timescale 1ns/1ps
`include "acc_settings.svh"

module tb_pe_array;
    import noc_pkg::*;
    import pe_pkg::*;

    localparam int NUM_PE = `ACC_NUM_ROW * `ACC_NUM_COL;
    localparam int PSUM_W = $bits(psum_t);
    // Cycles per test with the drain
    localparam int CYC_RESET = 16;
    localparam int CYC_TESTS = 6 + 10 + 18 + 12 + 22;
    localparam int CYCLE_LIMIT = CYC_RESET + CYC_TESTS + 40;

    logic                     clk;
    logic                     rstn;
    logic                     flush_tag;
    logic                     word_valid;
    bus_word_u                bus_word;
    logic                     flush_kernel;
    ksize_t                   kernel_size;
    logic [NUM_PE-1:0]        psum_valid;
    logic [NUM_PE*PSUM_W-1:0] psum_data;

    // Reference model state with one slot per PE
    int    model_row_tag;
    int    model_col_tag;
    psum_t model_sum [NUM_PE];
    int    model_cnt [NUM_PE];
    int    model_win [NUM_PE];
    psum_t model_out [NUM_PE];
    // Expected outputs three edges behind the top
    logic [NUM_PE-1:0]        exp_valid_dl [3];
    logic [NUM_PE*PSUM_W-1:0] exp_data_dl [3];

    string test_name;
    int    value_errs;
    int    strobe_errs;
    int    cycle_cnt;

    pe_array_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .flush_tag    (flush_tag),
        .word_valid   (word_valid),
        .bus_word     (bus_word),
        .flush_kernel (flush_kernel),
        .kernel_size  (kernel_size),
        .psum_valid   (psum_valid),
        .psum_data    (psum_data)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Tag value equal to the count means every row or column
    function automatic bit pe_hit(input int r, input int c, input int rt, input int ct);
        return ((rt == r) || (rt == `ACC_NUM_ROW)) && ((ct == c) || (ct == `ACC_NUM_COL));
    endfunction

    always @(posedge clk or negedge rstn) begin
        psum_t                    prod;
        logic [NUM_PE-1:0]        v_new;
        logic [NUM_PE*PSUM_W-1:0] d_new;
        if (!rstn) begin
            model_row_tag = `ACC_NUM_ROW;
            model_col_tag = `ACC_NUM_COL;
            for (int i = 0; i < NUM_PE; i++) begin
                model_sum[i] = '0;
                model_cnt[i] = 0;
                model_win[i] = 1;
                model_out[i] = '0;
            end
            for (int k = 0; k < 3; k++) begin
                exp_valid_dl[k] <= '0;
                exp_data_dl[k]  <= '0;
            end
        end else begin
            v_new = '0;
            // Signed 16x16 product kept to 32 bits
            prod = psum_t'(operand_t'(bus_word.data.ifmap))
                 * psum_t'(operand_t'(bus_word.data.fltr));
            for (int i = 0; i < NUM_PE; i++) begin
                if (flush_kernel) begin
                    model_sum[i] = '0;
                    model_cnt[i] = 0;
                    model_win[i] = int'(kernel_size);
                end else if (word_valid && pe_hit(i / `ACC_NUM_COL, i % `ACC_NUM_COL,
                                                  model_row_tag, model_col_tag)) begin
                    model_sum[i] = model_sum[i] + prod;
                    model_cnt[i]++;
                    // Window full so emit and restart
                    if (model_cnt[i] == model_win[i]) begin
                        v_new[i]     = 1'b1;
                        model_out[i] = model_sum[i];
                        model_sum[i] = '0;
                        model_cnt[i] = 0;
                    end
                end
                d_new[i*PSUM_W +: PSUM_W] = model_out[i];
            end
            // New tag only applies to later words
            if (flush_tag) begin
                model_row_tag = int'(bus_word.cfg.row_tag);
                model_col_tag = int'(bus_word.cfg.col_tag);
            end
            exp_valid_dl[0] <= v_new;
            exp_valid_dl[1] <= exp_valid_dl[0];
            exp_valid_dl[2] <= exp_valid_dl[1];
            exp_data_dl[0]  <= d_new;
            exp_data_dl[1]  <= exp_data_dl[0];
            exp_data_dl[2]  <= exp_data_dl[1];
        end
    end

    ////////////////////////////////////////
    // Output checks on every PE every cycle
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_PE; i++) begin : g_chk
        a_strobe: assert property (@(posedge clk) disable iff (!rstn)
            psum_valid[i] == exp_valid_dl[2][i])
            else begin
                strobe_errs++;
                if ($sampled(exp_valid_dl[2][i]))
                    $display("Test %s: PE %0d missed its psum strobe", test_name, i);
                else
                    $display("Test %s: PE %0d strobed with no window done", test_name, i);
            end

        a_psum: assert property (@(posedge clk) disable iff (!rstn)
            psum_data[i*PSUM_W +: PSUM_W] == exp_data_dl[2][i*PSUM_W +: PSUM_W])
            else begin
                value_errs++;
                $display("** Error %s: PE %0d psum expected %0d actual %0d", test_name, i,
                         $signed($sampled(exp_data_dl[2][i*PSUM_W +: PSUM_W])),
                         $signed($sampled(psum_data[i*PSUM_W +: PSUM_W])));
            end
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    task automatic send_tag(input int row, input int col);
        bus_word_u w;
        w             = '0;
        w.cfg.row_tag = row_tag_t'(row);
        w.cfg.col_tag = col_tag_t'(col);
        @(posedge clk);
        flush_tag    <= 1'b1;
        word_valid   <= 1'b0;
        flush_kernel <= 1'b0;
        bus_word     <= w;
    endtask

    // One data word with random operands
    task automatic send_word();
        bus_word_u w;
        w.data.ifmap = 16'($urandom);
        w.data.fltr  = 16'($urandom);
        @(posedge clk);
        flush_tag    <= 1'b0;
        word_valid   <= 1'b1;
        flush_kernel <= 1'b0;
        bus_word     <= w;
    endtask

    task automatic restart_window(input int size);
        @(posedge clk);
        flush_tag    <= 1'b0;
        word_valid   <= 1'b0;
        flush_kernel <= 1'b1;
        kernel_size  <= ksize_t'(size);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            flush_tag    <= 1'b0;
            word_valid   <= 1'b0;
            flush_kernel <= 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h6059));
        clk          = 1'b0;
        rstn         = 1'b0;
        flush_tag    = 1'b0;
        word_valid   = 1'b0;
        bus_word     = '0;
        flush_kernel = 1'b0;
        kernel_size  = 8'd1;
        test_name    = "reset_state";
        value_errs   = 0;
        strobe_errs  = 0;
        repeat (CYC_RESET) @(posedge clk);
        rstn <= 1'b1;

        // Reset tag hits all PEs with a window of 1
        send_word();
        idle_cycles(5);

        test_name = "unicast";
        send_tag(1, 2);
        restart_window(3);
        repeat (3) send_word();
        idle_cycles(5);

        test_name = "multicast";
        send_tag(2, `ACC_NUM_COL);
        repeat (3) send_word();
        idle_cycles(5);
        send_tag(`ACC_NUM_ROW, 1);
        repeat (3) send_word();
        idle_cycles(5);

        // Half window dropped and only the new window counts
        test_name = "kernel_flush";
        send_tag(0, `ACC_NUM_COL);
        restart_window(4);
        repeat (2) send_word();
        restart_window(2);
        repeat (2) send_word();
        idle_cycles(5);

        test_name = "pipelined_tags";
        restart_window(1);
        repeat (8) begin
            send_tag(int'($urandom_range(0, `ACC_NUM_ROW)),
                     int'($urandom_range(0, `ACC_NUM_COL)));
            send_word();
        end
        idle_cycles(5);

        $display("Checks done: %0d value errors, %0d strobe errors", value_errs, strobe_errs);
        if (value_errs + strobe_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Hang guard
    initial cycle_cnt = 0;
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: test %s still running after %0d cycles", test_name, cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule
